// ==== hw/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// data path and register file geometry
`define EXU_XLEN        64
`define EXU_REG_AW      5

// opcode field width, room for the illegal encodings too
`define EXU_OP_W        4

// input FIFO slots, equal to the issuer credits after reset
`define EXU_IN_DEPTH    4

// downstream slots the sender may fill after reset
`define EXU_OUT_CREDITS 2

// multiplier bits retired per cycle
`define EXU_MUL_BITS    4

`endif

// ==== hw/exu_pkg.sv ====
`include "exu_macros.svh"

package exu_pkg;

    // ALU operation codes, encodings above MUL are illegal
    typedef enum logic [`EXU_OP_W-1:0] {
        EXU_OP_ADD  = 0,
        EXU_OP_SUB  = 1,
        EXU_OP_AND  = 2,
        EXU_OP_OR   = 3,
        EXU_OP_XOR  = 4,
        EXU_OP_SLL  = 5,
        EXU_OP_SRL  = 6,
        EXU_OP_SRA  = 7,
        EXU_OP_SLT  = 8,
        EXU_OP_SLTU = 9,
        EXU_OP_MUL  = 10     // low half of the product
    } exu_op_e;

    // decoded operation as held in the input FIFO and ID/EX
    typedef struct packed {
        logic [`EXU_XLEN-1:0]   pc;
        exu_op_e                alu_op;
        logic [`EXU_XLEN-1:0]   src1;
        logic [`EXU_XLEN-1:0]   src2;
        logic [`EXU_REG_AW-1:0] rd;     // destination register
        logic                   wen;    // write rd at writeback
    } exu_op_t;

    // writeback record as held in EX/WB and sent downstream
    typedef struct packed {
        logic [`EXU_XLEN-1:0]   pc;
        logic [`EXU_REG_AW-1:0] rd;
        logic                   wen;
        logic [`EXU_XLEN-1:0]   result;
        logic                   illegal; // undefined opcode seen
    } exu_wb_t;

endpackage

// ==== hw/exu_stage_reg.sv ====
`timescale 1ns/1ps

module exu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_i,     // stall, keep content
    input  logic     load_i,     // current content leaves this cycle
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;
    logic     take;

    // refill when the old content leaves or the slot is empty
    assign take = !hold_i && (load_i || !valid_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (take) begin
            valid_q <= valid_i;    // a bubble clears the slot
            data_q  <= data_i;
        end else if (load_i) begin
            valid_q <= 1'b0;       // consumed while held, leave a bubble
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== hw/exu_in_buffer.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_in_buffer
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push_i,
    input  exu_op_t push_data_i,
    input  logic    pop_i,          // ID/EX ready to take the head
    output exu_op_t head_o,
    output logic    head_valid_o,
    output logic    credit_o
);

    localparam int unsigned DEPTH = `EXU_IN_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = PTR_W + 1;

    exu_op_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;
    logic             full;

    assign full         = (count_q == CNT_W'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign do_pop       = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= do_pop;     // one credit back per popped op
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // issuer must never push beyond the credits it was given
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full)
        else $error("push into full input buffer");

endmodule

// ==== hw/exu_execute.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_execute
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    op_valid_i,
    input  exu_op_t op_i,
    input  logic    wb_full_i,      // EX/WB holds a record
    input  logic    wb_sent_i,      // that record leaves this cycle
    output logic    stall_o,
    output logic    res_valid_o,
    output exu_wb_t res_o
);

    localparam int unsigned XLEN      = `EXU_XLEN;
    localparam int unsigned STEP_W    = `EXU_MUL_BITS;
    localparam int unsigned MUL_STEPS = XLEN / STEP_W;
    localparam int unsigned CNT_W     = $clog2(MUL_STEPS);
    localparam int unsigned SHAMT_W   = $clog2(XLEN);

    logic [XLEN-1:0]    alu_res;
    logic               illegal;
    logic [SHAMT_W-1:0] shamt;
    logic               wb_block;

    logic               is_mul;
    logic               mul_start;
    logic               mul_last;
    logic               mul_busy;
    logic               mul_busy_q;
    logic [CNT_W-1:0]   mul_cnt_q;
    logic [XLEN-1:0]    mul_acc_q;
    logic [XLEN-1:0]    mul_mcand_q;
    logic [XLEN-1:0]    mul_mplier_q;
    logic [XLEN-1:0]    step_acc;
    logic [XLEN-1:0]    step_mcand;
    logic [XLEN-1:0]    step_mplier;
    logic [XLEN-1:0]    step_sum;

    assign shamt = op_i.src2[SHAMT_W-1:0];

    always_comb begin
        alu_res = '0;
        illegal = 1'b0;
        case (op_i.alu_op)
            EXU_OP_ADD:  alu_res = op_i.src1 + op_i.src2;
            EXU_OP_SUB:  alu_res = op_i.src1 - op_i.src2;
            EXU_OP_AND:  alu_res = op_i.src1 & op_i.src2;
            EXU_OP_OR:   alu_res = op_i.src1 | op_i.src2;
            EXU_OP_XOR:  alu_res = op_i.src1 ^ op_i.src2;
            EXU_OP_SLL:  alu_res = op_i.src1 << shamt;
            EXU_OP_SRL:  alu_res = op_i.src1 >> shamt;
            EXU_OP_SRA:  alu_res = $signed(op_i.src1) >>> shamt;
            EXU_OP_SLT:  alu_res = XLEN'($signed(op_i.src1) < $signed(op_i.src2));
            EXU_OP_SLTU: alu_res = XLEN'(op_i.src1 < op_i.src2);
            EXU_OP_MUL:  alu_res = step_sum;    // valid on the last step only
            default:     illegal = 1'b1;        // result stays zero
        endcase
    end

    assign is_mul    = op_valid_i && (op_i.alu_op == EXU_OP_MUL);
    assign mul_start = is_mul && !mul_busy_q;
    assign mul_last  = mul_busy_q && (mul_cnt_q == CNT_W'(MUL_STEPS - 1));
    assign mul_busy  = mul_start || (mul_busy_q && !mul_last);
    assign wb_block  = wb_full_i && !wb_sent_i;

    // step 0 runs straight from the operands in the start cycle
    assign step_acc    = mul_busy_q ? mul_acc_q    : '0;
    assign step_mcand  = mul_busy_q ? mul_mcand_q  : op_i.src1;
    assign step_mplier = mul_busy_q ? mul_mplier_q : op_i.src2;
    assign step_sum    = step_acc + step_mcand * step_mplier[STEP_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_busy_q <= 1'b0;
            mul_cnt_q  <= '0;
        end else if (mul_start) begin
            mul_busy_q <= 1'b1;
            mul_cnt_q  <= CNT_W'(1);
        end else if (mul_busy_q && !(mul_last && wb_block)) begin
            mul_busy_q <= !mul_last;    // last step waits for EX/WB room
            mul_cnt_q  <= mul_cnt_q + 1'b1;
        end
    end

    // partial product state that the last step never writes
    always_ff @(posedge clk) begin
        if (mul_busy) begin
            mul_acc_q    <= step_sum;
            mul_mcand_q  <= step_mcand << STEP_W;
            mul_mplier_q <= step_mplier >> STEP_W;
        end
    end

    assign stall_o     = mul_busy || wb_block;
    assign res_valid_o = op_valid_i && !mul_busy;

    assign res_o.pc      = op_i.pc;
    assign res_o.rd      = op_i.rd;
    assign res_o.wen     = op_i.wen;
    assign res_o.result  = alu_res;
    assign res_o.illegal = illegal;

    // a new multiply starts only from an idle step counter
    a_mul_cnt_idle: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> (mul_cnt_q == '0))
        else $error("multiplier counter started while busy");

    // ID/EX keeps the multiply in place until it finishes
    a_mul_op_held: assert property (@(posedge clk) disable iff (!rst_n)
        mul_busy_q |-> is_mul && $stable(op_i))
        else $error("ID/EX changed during multiply");

endmodule

// ==== hw/exu_wb_sender.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_wb_sender
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wb_valid_i,
    input  exu_wb_t wb_i,
    input  logic    credit_i,       // slot freed downstream
    output logic    sent_o,
    output logic    out_valid_o,
    output exu_wb_t out_wb_o
);

    localparam int unsigned MAX_CRED = `EXU_OUT_CREDITS;
    localparam int unsigned CRED_W   = $clog2(MAX_CRED + 1);

    logic [CRED_W-1:0] credits_q;
    logic              send;

    assign send = wb_valid_i && (credits_q != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= CRED_W'(MAX_CRED);
        end else begin
            case ({send, credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;    // none, or send and return together
            endcase
        end
    end

    assign out_valid_o = send;
    assign out_wb_o    = wb_i;
    assign sent_o      = send;

    // downstream never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits_q <= CRED_W'(MAX_CRED))
        else $error("output credit count overflow");

endmodule

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps

module exu_top
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  exu_op_t in_op_i,
    output logic    in_credit_o,
    output logic    out_valid_o,
    output exu_wb_t out_wb_o,
    input  logic    out_credit_i
);

    exu_op_t head;
    logic    head_valid;
    logic    stall;
    logic    advance;
    logic    id_ex_valid;
    exu_op_t id_ex_op;
    logic    res_valid;
    exu_wb_t res;
    logic    ex_wb_valid;
    exu_wb_t ex_wb;
    logic    wb_sent;

    assign advance = !stall;    // ID/EX moves and FIFO pops together

    exu_in_buffer u_in_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (in_valid_i),
        .push_data_i  (in_op_i),
        .pop_i        (advance),
        .head_o       (head),
        .head_valid_o (head_valid),
        .credit_o     (in_credit_o)
    );

    exu_stage_reg #(.payload_t(exu_op_t)) u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (stall),
        .load_i  (advance),
        .valid_i (head_valid),
        .data_i  (head),
        .valid_o (id_ex_valid),
        .data_o  (id_ex_op)
    );

    exu_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid_i  (id_ex_valid),
        .op_i        (id_ex_op),
        .wb_full_i   (ex_wb_valid),
        .wb_sent_i   (wb_sent),
        .stall_o     (stall),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    // EX/WB drops its record once sent, even while the pipe stalls
    exu_stage_reg #(.payload_t(exu_wb_t)) u_ex_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (stall),
        .load_i  (wb_sent),
        .valid_i (res_valid),
        .data_i  (res),
        .valid_o (ex_wb_valid),
        .data_o  (ex_wb)
    );

    exu_wb_sender u_wb_sender (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_valid_i  (ex_wb_valid),
        .wb_i        (ex_wb),
        .credit_i    (out_credit_i),
        .sent_o      (wb_sent),
        .out_valid_o (out_valid_o),
        .out_wb_o    (out_wb_o)
    );

endmodule

// ==== sim/exu_tb.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_tb
    import exu_pkg::*;
();

    localparam int XLEN           = `EXU_XLEN;
    localparam int N_RAND_PER_OP  = 6;
    localparam int N_SHIFT        = 12;
    localparam int N_CMP          = 8;
    localparam int N_MUL_PAIRS    = 12;
    localparam int N_ILLEGAL      = 5;
    localparam int N_BACKPRESSURE = 12;
    localparam int NUM_OPS        = 10 * N_RAND_PER_OP + N_SHIFT + N_CMP + 2 * N_MUL_PAIRS
                                  + N_ILLEGAL + N_BACKPRESSURE;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 2000;
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] MAX_VAL = {1'b0, {(XLEN-1){1'b1}}};

    logic    clk          = 1'b0;
    logic    rst_n        = 1'b0;
    logic    in_valid_i   = 1'b0;
    exu_op_t in_op_i      = '0;
    logic    in_credit_o;
    logic    out_valid_o;
    exu_wb_t out_wb_o;
    logic    out_credit_i = 1'b0;

    exu_op_t         send_q[$];             // waiting for an issue credit
    exu_op_t         exp_q[$];              // issued but not yet written back
    int              due_q[$];              // cycle at which a downstream slot frees
    int              delay_tab[64];
    int              delay_idx     = 0;
    int              issue_credits = `EXU_IN_DEPTH;
    int              credits_back  = 0;
    int              issued_cnt    = 0;
    int              recv_cnt      = 0;
    int              ret_cnt       = 0;
    int              ds_cycle      = 0;
    int              checks        = 0;
    int              errors        = 0;
    logic            withhold      = 1'b0;  // downstream keeps its credits
    logic [XLEN-1:0] next_pc       = 64'h1000;

    exu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_op_i      (in_op_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_wb_o     (out_wb_o),
        .out_credit_i (out_credit_i)
    );

    always #5 clk = ~clk;

    // expected writeback record straight from the operation rules
    function automatic exu_wb_t exu_ref(input exu_op_t op);
        exu_wb_t         wb;
        logic [5:0]      sh;
        logic [XLEN-1:0] fill;
        sh        = op.src2[5:0];
        fill      = op.src1[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
        wb.pc     = op.pc;
        wb.rd     = op.rd;
        wb.wen    = op.wen;
        wb.result = '0;
        wb.illegal = 1'b0;
        case (op.alu_op)
            EXU_OP_ADD:  wb.result = op.src1 + op.src2;
            EXU_OP_SUB:  wb.result = op.src1 + ~op.src2 + 1'b1;
            EXU_OP_AND:  wb.result = op.src1 & op.src2;
            EXU_OP_OR:   wb.result = op.src1 | op.src2;
            EXU_OP_XOR:  wb.result = op.src1 ^ op.src2;
            EXU_OP_SLL:  wb.result = op.src1 << sh;
            EXU_OP_SRL:  wb.result = op.src1 >> sh;
            EXU_OP_SRA:  wb.result = (op.src1 >> sh) | fill;
            EXU_OP_SLT: begin
                if (op.src1[XLEN-1] != op.src2[XLEN-1]) begin
                    wb.result = XLEN'(op.src1[XLEN-1]);   // negative side is smaller
                end else begin
                    wb.result = XLEN'(op.src1 < op.src2);
                end
            end
            EXU_OP_SLTU: wb.result = XLEN'(op.src1 < op.src2);
            EXU_OP_MUL:  wb.result = op.src1 * op.src2;  // low 64 bits
            default:     wb.illegal = 1'b1;
        endcase
        return wb;
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    task automatic queue_op(input exu_op_e code, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        exu_op_t op;
        op.pc     = next_pc;
        op.alu_op = code;
        op.src1   = a;
        op.src2   = b;
        op.rd     = `EXU_REG_AW'($urandom);
        op.wen    = 1'($urandom);
        next_pc   = next_pc + 4;
        send_q.push_back(op);
    endtask

    // wait until all ops are written back and all credits are home
    task automatic wait_drain();
        while (send_q.size() != 0 || exp_q.size() != 0 || ret_cnt != recv_cnt
               || issue_credits < `EXU_IN_DEPTH) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (issue_credits == `EXU_IN_DEPTH && credits_back == issued_cnt)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: %0d input credits returned for %0d issued",
                     $time, credits_back, issued_cnt);
        end
    endtask

    always @(posedge clk) begin : issue_ops
        exu_op_t op;
        if (rst_n) begin
            if (in_credit_o) begin
                issue_credits++;
                credits_back++;
            end
            if (send_q.size() != 0 && issue_credits > 0) begin
                op = send_q.pop_front();
                exp_q.push_back(op);
                issue_credits--;
                issued_cnt++;
                in_valid_i <= 1'b1;
                in_op_i    <= op;
            end else begin
                in_valid_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : downstream_model
        if (rst_n) begin
            ds_cycle++;
            if (out_valid_o) begin
                recv_cnt++;
                assert (recv_cnt - ret_cnt <= `EXU_OUT_CREDITS)
                else begin
                    errors++;
                    $display("ERROR: record sent without an output credit at %0t", $time);
                end
                due_q.push_back(ds_cycle + delay_tab[delay_idx]);
                delay_idx = (delay_idx + 1) % 64;
            end
            if (out_credit_i) begin
                ret_cnt++;
            end
            if (!withhold && due_q.size() != 0 && due_q[0] <= ds_cycle) begin
                out_credit_i <= 1'b1;
                due_q.delete(0);
            end else begin
                out_credit_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare_results
        exu_op_t op;
        exu_wb_t want;
        string   fields;
        if (rst_n && out_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: writeback record at %0t with no operation outstanding", $time);
            end else begin
                op   = exp_q.pop_front();
                want = exu_ref(op);
                checks++;
                assert (out_wb_o == want)
                else begin
                    errors++;
                    fields = $sformatf("got/exp pc %h/%h rd %0d/%0d wen %b/%b",
                                       out_wb_o.pc, want.pc, out_wb_o.rd, want.rd,
                                       out_wb_o.wen, want.wen);
                    $display("CHECK FAILED at %0t: op %0d %s result %h/%h illegal %b/%b",
                             $time, op.alu_op, fields, out_wb_o.result, want.result,
                             out_wb_o.illegal, want.illegal);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        errors++;
        $display("ERROR: outputs stopped arriving, %0d of %0d records after %0d cycles",
                 recv_cnt, issued_cnt, WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        int              i;
        int              bp_recv_start;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;

        void'($urandom(36954));
        for (i = 0; i < 64; i++) begin
            delay_tab[i] = $urandom_range(5, 0);
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (10) begin
            @(negedge clk);
            assert (!in_credit_o && !out_valid_o)
            else begin
                errors++;
                $display("CHECK FAILED at %0t: outputs active after reset", $time);
            end
        end

        for (i = 0; i < 10 * N_RAND_PER_OP; i++) begin
            queue_op(exu_op_e'(4'(i % 10)), rand64(), rand64());
        end
        // shift amounts past 31 and junk in the upper src2 bits
        for (i = 0; i < N_SHIFT; i++) begin
            case (i % 4)
                0:       b = 64'd32;
                1:       b = 64'd33;
                2:       b = 64'd63;
                default: b = 64'hFFFF_FFFF_FFFF_FF45;
            endcase
            queue_op(exu_op_e'(4'(EXU_OP_SLL + i / 4)), 64'hF0F0_1234_5678_0F0F, b);
        end
        for (i = 0; i < N_CMP; i++) begin
            case (i / 2)
                0:       begin a = '1;      b = 64'd1;   end
                1:       begin a = 64'd1;   b = '1;      end
                2:       begin a = MIN_VAL; b = MAX_VAL; end
                default: begin a = 64'hFFFF_FFFF_FFFF_FFFB; b = 64'hFFFF_FFFF_FFFF_FFFD; end
            endcase
            queue_op(exu_op_e'((i % 2) ? EXU_OP_SLTU : EXU_OP_SLT), a, b);
        end
        wait_drain();

        // each multiply followed by an ALU op that must not overtake it
        for (i = 0; i < N_MUL_PAIRS; i++) begin
            case (i)
                0:       begin a = '0;      b = rand64(); end
                1:       begin a = rand64(); b = '0;      end
                2:       begin a = '1;      b = '1;      end
                3:       begin a = MIN_VAL; b = MIN_VAL; end
                4:       begin a = MIN_VAL; b = '1;      end
                5:       begin a = MAX_VAL; b = 64'd2;   end
                default: begin a = rand64(); b = rand64(); end
            endcase
            queue_op(EXU_OP_MUL, a, b);
            queue_op(EXU_OP_ADD, rand64(), rand64());
        end
        wait_drain();

        for (i = 0; i < N_ILLEGAL; i++) begin
            queue_op(exu_op_e'(4'(11 + i)), rand64(), rand64());
        end
        wait_drain();

        @(negedge clk);
        withhold      = 1'b1;
        bp_recv_start = recv_cnt;
        for (i = 0; i < N_BACKPRESSURE; i++) begin
            queue_op(exu_op_e'(4'($urandom_range(10, 0))), rand64(), rand64());
        end
        repeat (100) @(negedge clk);
        assert (recv_cnt - bp_recv_start == `EXU_OUT_CREDITS && issue_credits == 0)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: back-pressure gave %0d sends, %0d issue credits",
                     $time, recv_cnt - bp_recv_start, issue_credits);
        end
        withhold = 1'b0;
        wait_drain();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/exu_pkg.sv
hw/exu_stage_reg.sv
hw/exu_in_buffer.sv
hw/exu_execute.sv
hw/exu_wb_sender.sv
hw/exu_top.sv
sim/exu_tb.sv

// ==== Bender.yml ====
package:
  name: exu_slice

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/exu_pkg.sv
      - hw/exu_stage_reg.sv
      - hw/exu_in_buffer.sv
      - hw/exu_execute.sv
      - hw/exu_wb_sender.sv
      - hw/exu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/exu_tb.sv
